/* hdl/sdram_pkg.sv */
package sdram_pkg;

   // Device pins
   localparam int ADDR_BITS = 13;
   localparam int BA_BITS   = 2;
   localparam int DQ_BITS   = 16;
   localparam int DM_BITS   = 2;
   localparam int COL_BITS  = 8;
   localparam int AP_BIT    = 10;  // A10 selects auto-precharge / all banks

   // Power-up wait is 200 us at 50 MHz, divided down so simulation stays short
   localparam int POWERUP_NS    = 200_000;
   localparam int CLK_PERIOD_NS = 20;
   localparam int SIM_SCALE     = 100;
   localparam int T_POWERUP     = POWERUP_NS / CLK_PERIOD_NS / SIM_SCALE;

   localparam int T_RP             = 2;    // Precharge period
   localparam int T_RCD            = 2;    // ACTIVE to READ/WRITE
   localparam int T_RFC            = 7;    // Refresh cycle
   localparam int T_MRD            = 2;    // Mode register set
   localparam int CAS_LATENCY      = 2;
   localparam int REFRESH_INTERVAL = 780;  // 15.6 us at 20 ns

   localparam int INIT_CNT_W = $clog2(T_POWERUP);
   localparam int REF_CNT_W  = $clog2(REFRESH_INTERVAL);
   localparam int SEQ_CNT_W  = 4;

   // {CS, WE, RAS, CAS}, all active low
   typedef enum logic [3:0] {
      NOP          = 4'b0111,
      ACTIVE       = 4'b0101,
      READ         = 4'b0110,
      WRITE        = 4'b0010,
      PRECHARGE    = 4'b0001,
      AUTO_REFRESH = 4'b0100,
      LOAD_MODE    = 4'b0000
   } sdram_cmd_e;

   typedef struct packed {
      sdram_cmd_e           cmd;
      logic [BA_BITS-1:0]   ba;
      logic [ADDR_BITS-1:0] addr;
   } sdram_cmd_t;

   localparam logic [ADDR_BITS-1:0] AP_MASK = ADDR_BITS'(1) << AP_BIT;

   // Write burst = programmed, CL 2, sequential, BL 8
   localparam logic [ADDR_BITS-1:0] MODE_WORD = 13'b000_0_00_010_0_011;

   localparam sdram_cmd_t NOP_CMD = '{cmd: NOP, ba: '0, addr: '0};

endpackage

/* hdl/fb_cmd_pkg.sv */
package fb_cmd_pkg;

   localparam int CMD_ADDR_WIDTH = 23;
   localparam int DW             = 16;
   localparam int BURST_LEN      = 8;

   // Word address is {bank, row, column}
   localparam int BANK_W   = 2;
   localparam int ROW_W    = 13;
   localparam int COL_W    = 8;
   localparam int COL_LSB  = 0;
   localparam int ROW_LSB  = COL_LSB + COL_W;
   localparam int BANK_LSB = ROW_LSB + ROW_W;

   typedef enum logic [1:0] {
      WRITE_BURST,
      READ_BURST,
      REFRESH
   } job_kind_e;

   typedef struct packed {
      job_kind_e         kind;
      logic [BANK_W-1:0] bank;
      logic [ROW_W-1:0]  row;
      logic [COL_W-1:0]  col;
   } fb_job_t;

endpackage

/* hdl/sdram_init_refresh.sv */
`timescale 1ns/1ns

module sdram_init_refresh (
   input  logic                  clk,
   input  logic                  rst,
   output logic                  dram_cke,
   output sdram_pkg::sdram_cmd_t init_cmd,
   output logic                  init_done,
   output logic                  refresh_req
);
   import sdram_pkg::*;

   typedef enum logic [2:0] {ST_POWER, ST_PRE, ST_REF1, ST_REF2, ST_MODE, ST_DONE} init_st_e;

   init_st_e              state;
   logic [INIT_CNT_W-1:0] cnt;
   logic [REF_CNT_W-1:0]  ref_cnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ST_POWER;
         cnt       <= INIT_CNT_W'(T_POWERUP - 1);
         dram_cke  <= 1'b0;
         init_cmd  <= NOP_CMD;
         init_done <= 1'b0;
      end else begin
         init_cmd <= NOP_CMD;
         if (state == ST_POWER && cnt == INIT_CNT_W'(1))
            dram_cke <= 1'b1;  // CKE up one cycle before the first command
         if (cnt != '0) begin
            cnt <= cnt - 1'b1;
         end else begin
            case (state)
               ST_POWER: begin
                  init_cmd <= '{cmd: PRECHARGE, ba: '0, addr: AP_MASK};  // All banks
                  cnt      <= INIT_CNT_W'(T_RP - 1);
                  state    <= ST_PRE;
               end
               ST_PRE: begin
                  init_cmd <= '{cmd: AUTO_REFRESH, ba: '0, addr: '0};
                  cnt      <= INIT_CNT_W'(T_RFC - 1);
                  state    <= ST_REF1;
               end
               ST_REF1: begin
                  init_cmd <= '{cmd: AUTO_REFRESH, ba: '0, addr: '0};
                  cnt      <= INIT_CNT_W'(T_RFC - 1);
                  state    <= ST_REF2;
               end
               ST_REF2: begin
                  init_cmd <= '{cmd: LOAD_MODE, ba: '0, addr: MODE_WORD};
                  cnt      <= INIT_CNT_W'(T_MRD - 1);
                  state    <= ST_MODE;
               end
               ST_MODE: begin
                  init_done <= 1'b1;  // tMRD elapsed
                  state     <= ST_DONE;
               end
               default: ;
            endcase
         end
      end
   end

   // Periodic refresh tick, free running once the device is up
   always_ff @(posedge clk) begin
      if (rst) begin
         ref_cnt     <= REF_CNT_W'(REFRESH_INTERVAL - 1);
         refresh_req <= 1'b0;
      end else begin
         refresh_req <= 1'b0;
         if (init_done) begin
            if (ref_cnt == '0) begin
               ref_cnt     <= REF_CNT_W'(REFRESH_INTERVAL - 1);
               refresh_req <= 1'b1;
            end else begin
               ref_cnt <= ref_cnt - 1'b1;
            end
         end
      end
   end

endmodule

/* hdl/sdram_cmd_arbiter.sv */
`timescale 1ns/1ns

module sdram_cmd_arbiter (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                init_done,
   input  logic                                refresh_req,
   input  logic                                we_req,
   input  logic                                rd_req,
   input  logic [fb_cmd_pkg::CMD_ADDR_WIDTH-1:0] cmd_addr,
   input  logic                                seq_idle,
   output logic                                we_ack,
   output logic                                rd_ack,
   output logic                                job_start,
   output fb_cmd_pkg::fb_job_t                 job
);
   import fb_cmd_pkg::*;

   logic [1:0] ref_pend;  // Refresh ticks not yet served
   logic       start_ok;
   logic       take_ref;
   logic       take_we;
   logic       take_rd;
   job_kind_e  kind_next;

   // Sequencer only drops seq_idle the cycle after job_start, so skip that cycle
   assign start_ok = init_done && seq_idle && !job_start;
   assign take_ref = start_ok && ref_pend != '0;
   assign take_we  = start_ok && ref_pend == '0 && we_req;
   assign take_rd  = start_ok && ref_pend == '0 && !we_req && rd_req;

   assign kind_next = take_ref ? REFRESH : (take_we ? WRITE_BURST : READ_BURST);

   always_ff @(posedge clk) begin
      if (rst) begin
         ref_pend  <= '0;
         job_start <= 1'b0;
         we_ack    <= 1'b0;
         rd_ack    <= 1'b0;
      end else begin
         job_start <= take_ref || take_we || take_rd;
         we_ack    <= job_start && job.kind == WRITE_BURST;  // Ack trails the start by one
         rd_ack    <= job_start && job.kind == READ_BURST;
         case ({refresh_req && ref_pend != 2'b11, take_ref})
            2'b10:   ref_pend <= ref_pend + 1'b1;
            2'b01:   ref_pend <= ref_pend - 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take_ref || take_we || take_rd)
         job <= '{kind: kind_next,
                  bank: cmd_addr[BANK_LSB +: BANK_W],
                  row:  cmd_addr[ROW_LSB +: ROW_W],
                  col:  cmd_addr[COL_LSB +: COL_W]};
   end

endmodule

/* hdl/sdram_cmd_sequencer.sv */
`timescale 1ns/1ns

module sdram_cmd_sequencer (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  init_done,
   input  logic                  job_start,
   input  sdram_pkg::sdram_cmd_t init_cmd,
   input  fb_cmd_pkg::fb_job_t   job,
   output sdram_pkg::sdram_cmd_t dram_cmd,
   output logic                  seq_idle,
   output logic                  wr_beat,
   output logic                  rd_beat
);
   import sdram_pkg::*;
   import fb_cmd_pkg::*;

   typedef enum logic [2:0] {ST_IDLE, ST_OPEN, ST_RCD, ST_BURST, ST_WAIT} seq_st_e;

   seq_st_e              state;
   logic [SEQ_CNT_W-1:0] cnt;
   fb_job_t              job_q;
   sdram_cmd_t           seq_cmd;

   assign seq_idle = (state == ST_IDLE);
   assign dram_cmd = init_done ? seq_cmd : init_cmd;  // Init stage owns the bus until done

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && job_start)
         job_q <= job;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_IDLE;
         cnt     <= '0;
         seq_cmd <= NOP_CMD;
         wr_beat <= 1'b0;
         rd_beat <= 1'b0;
      end else begin
         seq_cmd <= NOP_CMD;
         case (state)
            ST_IDLE: begin
               if (job_start)
                  state <= ST_OPEN;
            end
            ST_OPEN: begin
               if (job_q.kind == REFRESH) begin
                  seq_cmd <= '{cmd: AUTO_REFRESH, ba: '0, addr: '0};
                  cnt     <= SEQ_CNT_W'(T_RFC - 1);
                  state   <= ST_WAIT;
               end else begin
                  seq_cmd <= '{cmd: ACTIVE, ba: job_q.bank, addr: job_q.row};
                  cnt     <= SEQ_CNT_W'(T_RCD - 1);
                  state   <= ST_RCD;
               end
            end
            ST_RCD: begin
               // Write data is taken one cycle before the WRITE command
               if (cnt == SEQ_CNT_W'(1) && job_q.kind == WRITE_BURST)
                  wr_beat <= 1'b1;
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else begin
                  seq_cmd <= '{cmd: (job_q.kind == WRITE_BURST) ? WRITE : READ,
                               ba: job_q.bank,
                               addr: AP_MASK | ADDR_BITS'(job_q.col)};  // Auto-precharge
                  rd_beat <= (job_q.kind == READ_BURST);
                  cnt     <= SEQ_CNT_W'(BURST_LEN - 1);
                  state   <= ST_BURST;
               end
            end
            ST_BURST: begin
               if (cnt == SEQ_CNT_W'(1))
                  wr_beat <= 1'b0;
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else begin
                  rd_beat <= 1'b0;
                  cnt     <= SEQ_CNT_W'(T_RP - 1);  // Row closes by itself
                  state   <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (cnt != '0)
                  cnt <= cnt - 1'b1;
               else
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* hdl/sdram_data_path.sv */
`timescale 1ns/1ns

module sdram_data_path (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            wr_beat,
   input  logic                            rd_beat,
   input  logic [fb_cmd_pkg::DW-1:0]       din,
   inout  wire  [sdram_pkg::DQ_BITS-1:0]   dram_data,
   output logic                            w_rdy,
   output logic                            r_vld,
   output logic [fb_cmd_pkg::DW-1:0]       dout
);
   import sdram_pkg::*;

   logic [DQ_BITS-1:0]   dq_out;
   logic                 dq_oe;
   logic [CAS_LATENCY:0] rd_pipe;  // One stage per cycle of read latency

   // Ready leads the DQ drive by one cycle, the word is registered in between
   assign w_rdy     = wr_beat;
   assign dram_data = dq_oe ? dq_out : 'z;
   assign r_vld     = rd_pipe[CAS_LATENCY];

   always_ff @(posedge clk) begin
      if (rst) begin
         dq_oe   <= 1'b0;
         rd_pipe <= '0;
      end else begin
         dq_oe   <= wr_beat;
         rd_pipe <= {rd_pipe[CAS_LATENCY-1:0], rd_beat};
      end
   end

   always_ff @(posedge clk) begin
      if (wr_beat)
         dq_out <= din;
      if (rd_pipe[CAS_LATENCY-1])
         dout <= dram_data;  // Device word is on DQ CL cycles after READ
   end

endmodule

/* hdl/fb_sdram_ctrl.sv */
`timescale 1ns/1ns

module fb_sdram_ctrl (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  sdr_cmd_bst_we_req,
   input  logic                                  sdr_cmd_bst_rd_req,
   input  logic [fb_cmd_pkg::CMD_ADDR_WIDTH-1:0] sdr_cmd_addr,
   input  logic [fb_cmd_pkg::DW-1:0]             sdr_din,
   output logic                                  sdr_cmd_bst_we_ack,
   output logic                                  sdr_cmd_bst_rd_ack,
   output logic                                  sdr_w_rdy,
   output logic                                  sdr_r_vld,
   output logic [fb_cmd_pkg::DW-1:0]             sdr_dout,
   output logic                                  DRAM_CKE,
   output logic [3:0]                            DRAM_CS_WE_RAS_CAS_L,
   output logic [sdram_pkg::BA_BITS-1:0]         DRAM_BA,
   output logic [sdram_pkg::ADDR_BITS-1:0]       DRAM_ADDR,
   output logic [sdram_pkg::DM_BITS-1:0]         DRAM_DQM,
   inout  wire  [sdram_pkg::DQ_BITS-1:0]         DRAM_DATA
);
   import sdram_pkg::*;
   import fb_cmd_pkg::*;

   sdram_cmd_t init_cmd;
   sdram_cmd_t dram_cmd;
   fb_job_t    job;
   logic       init_done;
   logic       refresh_req;
   logic       seq_idle;
   logic       job_start;
   logic       wr_beat;
   logic       rd_beat;

   assign DRAM_CS_WE_RAS_CAS_L = dram_cmd.cmd;
   assign DRAM_BA              = dram_cmd.ba;
   assign DRAM_ADDR            = dram_cmd.addr;
   assign DRAM_DQM             = '0;  // No byte masking

   sdram_init_refresh init_refresh_i (
      .clk         (clk),
      .rst         (rst),
      .dram_cke    (DRAM_CKE),
      .init_cmd    (init_cmd),
      .init_done   (init_done),
      .refresh_req (refresh_req)
   );

   sdram_cmd_arbiter arbiter_i (
      .clk         (clk),
      .rst         (rst),
      .init_done   (init_done),
      .refresh_req (refresh_req),
      .we_req      (sdr_cmd_bst_we_req),
      .rd_req      (sdr_cmd_bst_rd_req),
      .cmd_addr    (sdr_cmd_addr),
      .seq_idle    (seq_idle),
      .we_ack      (sdr_cmd_bst_we_ack),
      .rd_ack      (sdr_cmd_bst_rd_ack),
      .job_start   (job_start),
      .job         (job)
   );

   sdram_cmd_sequencer sequencer_i (
      .clk       (clk),
      .rst       (rst),
      .init_done (init_done),
      .job_start (job_start),
      .init_cmd  (init_cmd),
      .job       (job),
      .dram_cmd  (dram_cmd),
      .seq_idle  (seq_idle),
      .wr_beat   (wr_beat),
      .rd_beat   (rd_beat)
   );

   sdram_data_path data_path_i (
      .clk       (clk),
      .rst       (rst),
      .wr_beat   (wr_beat),
      .rd_beat   (rd_beat),
      .din       (sdr_din),
      .dram_data (DRAM_DATA),
      .w_rdy     (sdr_w_rdy),
      .r_vld     (sdr_r_vld),
      .dout      (sdr_dout)
   );

endmodule

/* dv/sdram_model.sv */
`timescale 1ns/1ns

module sdram_model (
   input  logic                          clk,
   input  logic                          cke,
   input  sdram_pkg::sdram_cmd_t         cmd,
   inout  wire  [sdram_pkg::DQ_BITS-1:0] dq
);
   import sdram_pkg::*;

   localparam int WA_BITS = BA_BITS + ADDR_BITS + COL_BITS;  // {bank, row, col}
   localparam int BL_BITS = 3;                                // Burst of 8

   logic [DQ_BITS-1:0]   mem [logic [WA_BITS-1:0]];
   logic [3:0]           bank_open = '0;
   logic [ADDR_BITS-1:0] open_row [4];
   int                   act_cyc [4];
   int                   cyc = 0;
   int                   ref_cnt = 0;
   int                   err_cnt = 0;
   int                   cmd_num = 0;
   int                   mode_loads = 0;
   sdram_cmd_e           init_seq [4];  // First four commands after CKE
   logic [ADDR_BITS-1:0] mode_word = '0;
   logic [WA_BITS-1:0]   burst_base;
   int                   wr_left = 0;
   int                   rd_left = 0;
   int                   rd_wait = 0;
   logic [DQ_BITS-1:0]   dq_drv;
   logic                 dq_oe = 1'b0;

   assign dq = dq_oe ? dq_drv : 'z;

   // Sequential order wraps inside the aligned group of eight
   function automatic logic [WA_BITS-1:0] word_addr(logic [WA_BITS-1:0] base, int beat);
      return {base[WA_BITS-1:BL_BITS], BL_BITS'(base[BL_BITS-1:0] + beat)};
   endfunction

   function automatic logic [DQ_BITS-1:0] fetch(logic [WA_BITS-1:0] a);
      return mem.exists(a) ? mem[a] : 'x;
   endfunction

   task automatic flag(input string what);
      err_cnt++;
      $display("sdram model: %s, bank %0d at %0t", what, cmd.ba, $time);
   endtask

   always @(posedge clk) begin
      if (rd_left != 0) begin
         if (rd_wait != 0) begin
            rd_wait--;
         end else begin
            dq_drv <= fetch(word_addr(burst_base, 8 - rd_left));
            dq_oe  <= 1'b1;
            rd_left--;
         end
      end else begin
         dq_oe <= 1'b0;
      end
      if (wr_left != 0) begin
         mem[word_addr(burst_base, 8 - wr_left)] = dq;
         wr_left--;
      end
      if (cke) begin
         case (cmd.cmd)
            ACTIVE: begin
               if (bank_open[cmd.ba])
                  flag("ACTIVE to a bank that is still open");
               bank_open[cmd.ba] = 1'b1;
               open_row[cmd.ba]  = cmd.addr;
               act_cyc[cmd.ba]   = cyc;
            end
            READ, WRITE: begin
               if (!bank_open[cmd.ba])
                  flag("column command to a closed row");
               else if (cyc - act_cyc[cmd.ba] < T_RCD)
                  flag("column command sooner than tRCD after ACTIVE");
               burst_base = {cmd.ba, open_row[cmd.ba], cmd.addr[COL_BITS-1:0]};
               if (cmd.addr[AP_BIT])
                  bank_open[cmd.ba] = 1'b0;  // Auto-precharge
               if (cmd.cmd == WRITE) begin
                  mem[burst_base] = dq;  // First word comes with the command
                  wr_left = 7;
               end else begin
                  rd_left = 8;
                  rd_wait = CAS_LATENCY - 2;
               end
            end
            PRECHARGE: begin
               if (cmd.addr[AP_BIT])
                  bank_open = '0;
               else
                  bank_open[cmd.ba] = 1'b0;
            end
            AUTO_REFRESH: begin
               if (bank_open != '0)
                  flag("AUTO_REFRESH with a bank open");
               ref_cnt++;
            end
            LOAD_MODE: begin
               mode_word = cmd.addr;
               mode_loads++;
            end
            default: ;
         endcase
         if (cmd.cmd != NOP) begin
            if (cmd_num < 4)
               init_seq[cmd_num] = cmd.cmd;
            cmd_num++;
         end
      end
      cyc++;
   end

endmodule

/* dv/tb_fb_sdram_ctrl.sv */
`timescale 1ns/1ns

module tb_fb_sdram_ctrl;
   import sdram_pkg::*;
   import fb_cmd_pkg::*;

   localparam int          DRV_DLY      = 2;
   localparam int          RST_CYCLES   = 16;
   localparam int          INIT_TIMEOUT = 1000;
   localparam int          ACK_TIMEOUT  = 2000;
   localparam int          BEAT_TIMEOUT = 50;
   localparam int          IDLE_CYCLES  = 3 * REFRESH_INTERVAL;
   localparam int          BL_BITS      = $clog2(BURST_LEN);
   localparam logic [31:0] LFSR_SEED    = 32'hb20d;
   localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

   // Burst write, CL 2, sequential, BL 8
   localparam logic [ADDR_BITS-1:0] EXP_MODE_WORD = {3'b000, 1'b0, 2'b00, 3'd2, 1'b0, 3'd3};

   typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IDLE} op_e;

   typedef struct packed {
      op_e                       op;
      logic [CMD_ADDR_WIDTH-1:0] addr;
      logic                      reseed;  // Restart the write data stream
   } stim_t;

   stim_t stim [15] = '{
      '{OP_WRITE, 23'h000010, 1'b1},
      '{OP_READ,  23'h000010, 1'b0},
      '{OP_WRITE, 23'h200523, 1'b0},  // Start column not aligned
      '{OP_READ,  23'h200520, 1'b0},
      '{OP_WRITE, 23'h5abc40, 1'b0},
      '{OP_WRITE, 23'h6ffff8, 1'b0},
      '{OP_WRITE, 23'h400240, 1'b0},  // Same bank as 5abc40, other row
      '{OP_READ,  23'h5abc40, 1'b0},
      '{OP_READ,  23'h6ffff8, 1'b0},
      '{OP_READ,  23'h400240, 1'b0},
      '{OP_IDLE,  23'h000000, 1'b0},
      '{OP_READ,  23'h000010, 1'b0},
      '{OP_READ,  23'h200520, 1'b0},
      '{OP_WRITE, 23'h00001f, 1'b1},
      '{OP_READ,  23'h000018, 1'b0}
   };

   logic                      clk = 1'b0;
   logic                      rst;
   logic                      sdr_cmd_bst_we_req;
   logic                      sdr_cmd_bst_rd_req;
   logic [CMD_ADDR_WIDTH-1:0] sdr_cmd_addr;
   logic [DW-1:0]             sdr_din;
   logic                      sdr_cmd_bst_we_ack;
   logic                      sdr_cmd_bst_rd_ack;
   logic                      sdr_w_rdy;
   logic                      sdr_r_vld;
   logic [DW-1:0]             sdr_dout;
   logic                      DRAM_CKE;
   logic [3:0]                DRAM_CS_WE_RAS_CAS_L;
   logic [BA_BITS-1:0]        DRAM_BA;
   logic [ADDR_BITS-1:0]      DRAM_ADDR;
   logic [DM_BITS-1:0]        DRAM_DQM;
   wire  [DQ_BITS-1:0]        DRAM_DATA;
   sdram_cmd_t                dev_cmd;

   logic [31:0]               lfsr;
   logic [DW-1:0]             sb [logic [CMD_ADDR_WIDTH-1:0]];  // Last word written per address
   int                        err_cnt = 0;
   int                        check_cnt = 0;
   int                        test_err = 0;
   int                        tests_run = 0;
   int                        tests_failed = 0;
   int                        we_req_cnt = 0;
   int                        rd_req_cnt = 0;
   int                        we_ack_cnt = 0;
   int                        rd_ack_cnt = 0;
   bit                        hung = 1'b0;

   always #10 clk = ~clk;

   assign dev_cmd = {DRAM_CS_WE_RAS_CAS_L, DRAM_BA, DRAM_ADDR};

   fb_sdram_ctrl fb_sdram_ctrl_i (
      .clk                  (clk),
      .rst                  (rst),
      .sdr_cmd_bst_we_req   (sdr_cmd_bst_we_req),
      .sdr_cmd_bst_rd_req   (sdr_cmd_bst_rd_req),
      .sdr_cmd_addr         (sdr_cmd_addr),
      .sdr_din              (sdr_din),
      .sdr_cmd_bst_we_ack   (sdr_cmd_bst_we_ack),
      .sdr_cmd_bst_rd_ack   (sdr_cmd_bst_rd_ack),
      .sdr_w_rdy            (sdr_w_rdy),
      .sdr_r_vld            (sdr_r_vld),
      .sdr_dout             (sdr_dout),
      .DRAM_CKE             (DRAM_CKE),
      .DRAM_CS_WE_RAS_CAS_L (DRAM_CS_WE_RAS_CAS_L),
      .DRAM_BA              (DRAM_BA),
      .DRAM_ADDR            (DRAM_ADDR),
      .DRAM_DQM             (DRAM_DQM),
      .DRAM_DATA            (DRAM_DATA)
   );

   sdram_model model_i (
      .clk (clk),
      .cke (DRAM_CKE),
      .cmd (dev_cmd),
      .dq  (DRAM_DATA)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // One LFSR step per data bit
   function automatic logic [DW-1:0] next_word();
      logic [DW-1:0] w;
      w = '0;
      for (int b = 0; b < DW; b++) begin
         w    = {w[DW-2:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return w;
   endfunction

   function automatic logic [CMD_ADDR_WIDTH-1:0] burst_word_addr(
      input logic [CMD_ADDR_WIDTH-1:0] base, input int beat);
      return {base[CMD_ADDR_WIDTH-1:BL_BITS], BL_BITS'(base[BL_BITS-1:0] + beat)};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_cnt++;
      assert (got === exp) else begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         err_cnt++;
         test_err++;
      end
   endtask

   task automatic check_true(input bit ok, input string what);
      check_cnt++;
      assert (ok) else begin
         $display("Failure: %s", what);
         err_cnt++;
         test_err++;
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (test_err != 0)
         tests_failed++;
      $display("test %0d %s: %s", tests_run, name,
               test_err == 0 ? "ok" : $sformatf("%0d errors", test_err));
   endtask

   // Count ack pulses and flag any that precede the mode register load
   always @(negedge clk) begin
      if (sdr_cmd_bst_we_ack)
         we_ack_cnt++;
      if (sdr_cmd_bst_rd_ack)
         rd_ack_cnt++;
      if (sdr_cmd_bst_we_ack || sdr_cmd_bst_rd_ack)
         check_true(model_i.mode_loads != 0, "ack given before the device was initialized");
   end

   task automatic wait_ack(input bit is_write);
      int n;
      for (n = 0; n < ACK_TIMEOUT; n++) begin
         @(negedge clk);
         if (is_write ? sdr_cmd_bst_we_ack : sdr_cmd_bst_rd_ack)
            break;
      end
      if (n == ACK_TIMEOUT) begin
         hung = 1'b1;
         $display("Timeout: no %s ack within %0d cycles", is_write ? "write" : "read", n);
      end
   endtask

   task automatic wait_strobe(input bit is_write);
      int n;
      for (n = 0; n < BEAT_TIMEOUT; n++) begin
         @(negedge clk);
         if (is_write ? sdr_w_rdy : sdr_r_vld)
            break;
      end
      if (n == BEAT_TIMEOUT) begin
         hung = 1'b1;
         $display("Timeout: %s never rose after the ack", is_write ? "sdr_w_rdy" : "sdr_r_vld");
      end
   endtask

   task automatic reset_and_init();
      int n;
      rd_req_cnt++;  // Read request held since time zero
      repeat (RST_CYCLES) begin
         @(negedge clk);
         check_value("sdr_cmd_bst_we_ack", sdr_cmd_bst_we_ack, 0);
         check_value("sdr_cmd_bst_rd_ack", sdr_cmd_bst_rd_ack, 0);
         check_value("sdr_w_rdy", sdr_w_rdy, 0);
         check_value("sdr_r_vld", sdr_r_vld, 0);
         check_value("DRAM_CKE", DRAM_CKE, 0);
      end
      @(posedge clk);
      #DRV_DLY;
      rst = 1'b0;
      for (n = 0; n < INIT_TIMEOUT; n++) begin
         @(negedge clk);
         if (model_i.mode_loads != 0)
            break;
      end
      if (n == INIT_TIMEOUT) begin
         hung = 1'b1;
         $display("Timeout: the mode register was never loaded");
         return;
      end
      check_value("init command 0", model_i.init_seq[0], PRECHARGE);
      check_value("init command 1", model_i.init_seq[1], AUTO_REFRESH);
      check_value("init command 2", model_i.init_seq[2], AUTO_REFRESH);
      check_value("init command 3", model_i.init_seq[3], LOAD_MODE);
      check_value("mode word", model_i.mode_word, EXP_MODE_WORD);
      wait_ack(1'b0);
      if (hung)
         return;
      @(posedge clk);
      #DRV_DLY;
      sdr_cmd_bst_rd_req = 1'b0;
   endtask

   task automatic write_burst(input logic [CMD_ADDR_WIDTH-1:0] addr);
      logic [DW-1:0] words [BURST_LEN];
      int            beats;
      for (int i = 0; i < BURST_LEN; i++) begin
         words[i] = next_word();
         sb[burst_word_addr(addr, i)] = words[i];
      end
      @(posedge clk);
      #DRV_DLY;
      sdr_cmd_addr       = addr;
      sdr_din            = words[0];  // First word waits on the bus for ready
      sdr_cmd_bst_we_req = 1'b1;
      we_req_cnt++;
      wait_ack(1'b1);
      @(posedge clk);
      #DRV_DLY;
      sdr_cmd_bst_we_req = 1'b0;
      if (hung)
         return;
      wait_strobe(1'b1);
      beats = 0;
      while (!hung && sdr_w_rdy && beats <= BURST_LEN) begin
         check_value("DRAM_DQM", DRAM_DQM, 0);
         beats++;
         @(posedge clk);
         #DRV_DLY;
         if (beats < BURST_LEN)
            sdr_din = words[beats];
         @(negedge clk);
      end
      if (!hung)
         check_value("sdr_w_rdy cycles", beats, BURST_LEN);
   endtask

   task automatic read_burst(input logic [CMD_ADDR_WIDTH-1:0] addr);
      logic [DW-1:0] exp [BURST_LEN];
      int            beats;
      for (int i = 0; i < BURST_LEN; i++) begin
         check_true(sb.exists(burst_word_addr(addr, i)), "read of an address never written");
         exp[i] = sb.exists(burst_word_addr(addr, i)) ? sb[burst_word_addr(addr, i)] : 'x;
      end
      @(posedge clk);
      #DRV_DLY;
      sdr_cmd_addr       = addr;
      sdr_cmd_bst_rd_req = 1'b1;
      rd_req_cnt++;
      wait_ack(1'b0);
      @(posedge clk);
      #DRV_DLY;
      sdr_cmd_bst_rd_req = 1'b0;
      if (hung)
         return;
      wait_strobe(1'b0);
      beats = 0;
      while (!hung && sdr_r_vld && beats <= BURST_LEN) begin
         check_value("DRAM_DQM", DRAM_DQM, 0);
         if (beats < BURST_LEN)
            check_value("sdr_dout", sdr_dout, exp[beats]);
         beats++;
         @(negedge clk);
      end
      if (!hung)
         check_value("sdr_r_vld cycles", beats, BURST_LEN);
   endtask

   task automatic idle_stretch();
      int r0;
      r0 = model_i.ref_cnt;
      repeat (IDLE_CYCLES) @(negedge clk);
      check_true(model_i.ref_cnt - r0 >= IDLE_CYCLES / REFRESH_INTERVAL - 1,
                 "too few auto-refreshes during the idle stretch");
   endtask

   initial begin
      rst                = 1'b1;
      sdr_cmd_bst_we_req = 1'b0;
      sdr_cmd_bst_rd_req = 1'b1;  // Pending through reset and init
      sdr_cmd_addr       = '0;
      sdr_din            = '0;
      lfsr               = LFSR_SEED;
      reset_and_init();
      report_test("reset and initialization");
      for (int t = 0; t < $size(stim) && !hung; t++) begin
         stim_t s;
         s        = stim[t];
         test_err = 0;
         if (s.reseed)
            lfsr = LFSR_SEED;
         case (s.op)
            OP_WRITE: write_burst(s.addr);
            OP_READ:  read_burst(s.addr);
            default:  idle_stretch();
         endcase
         report_test($sformatf("%s %h", s.op.name(), s.addr));
      end
      if (!hung) begin
         test_err = 0;
         check_value("sdr_cmd_bst_we_ack pulses", we_ack_cnt, we_req_cnt);
         check_value("sdr_cmd_bst_rd_ack pulses", rd_ack_cnt, rd_req_cnt);
         check_value("model protocol errors", model_i.err_cnt, 0);
         report_test("ack totals and device protocol");
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_cnt, err_cnt);
      if (!hung && err_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* flist.f */
hdl/sdram_pkg.sv
hdl/fb_cmd_pkg.sv
hdl/sdram_init_refresh.sv
hdl/sdram_cmd_arbiter.sv
hdl/sdram_cmd_sequencer.sv
hdl/sdram_data_path.sv
hdl/fb_sdram_ctrl.sv
dv/sdram_model.sv
dv/tb_fb_sdram_ctrl.sv

/* Bender.yml */
package:
  name: fb_sdram_ctrl

sources:
  - hdl/sdram_pkg.sv
  - hdl/fb_cmd_pkg.sv
  - hdl/sdram_init_refresh.sv
  - hdl/sdram_cmd_arbiter.sv
  - hdl/sdram_cmd_sequencer.sv
  - hdl/sdram_data_path.sv
  - hdl/fb_sdram_ctrl.sv
  - target: test
    files:
      - dv/sdram_model.sv
      - dv/tb_fb_sdram_ctrl.sv
